// File: common/rc_params.svh
//======================================================================
// Timing constants of the RC input subsystem, all in microseconds
//======================================================================

`ifndef RC_PARAMS_SVH
`define RC_PARAMS_SVH

// Legal window for a servo pulse, anything outside is clamped to it
`define RC_MIN_PULSE_US 16'd1000
`define RC_MAX_PULSE_US 16'd2000

// Neutral stick position, also the power-up value of the axis readers
`define RC_CENTER_US 16'd1500

// Axis offsets up to this magnitude count as stick at rest
`define RC_DEADBAND_US 16'd20

// Cycles without a measured pulse before a channel is stale
`define RC_LINK_TIMEOUT_US 13'd4000

// Width of the stale counters, enough to hold the timeout
`define RC_LINK_CNT_W 13

`endif

// File: common/rc_pkg.sv
//======================================================================
// Shared types of the RC input subsystem: reader states, channel
// index, pulse-length bundle and flight command bundle
//======================================================================

package rc_pkg;

	// States of the per-channel PWM reader
	// The two confirm states hold a level change until it is seen twice
	typedef enum logic [2:0] {
		INIT,
		LOW,
		HIGH,
		CONFIRM_HIGH,
		CONFIRM_LOW
	} pwm_state_e;

	// Channel index, used for the pin vector and the done strobes
	typedef enum logic [1:0] {
		THROTTLE,
		ROLL,
		PITCH,
		YAW
	} rc_chan_e;

	// Measured high time of each channel in microseconds
	typedef struct packed {
		logic [15:0] throttle;
		logic [15:0] roll;
		logic [15:0] pitch;
		logic [15:0] yaw;
	} rc_pulses_t;

	// Flight commands handed to the controller
	// Throttle runs 0..1000 and the axes run -500..500 around centre
	typedef struct packed {
		logic        [9:0] throttle;
		logic signed [9:0] roll;
		logic signed [9:0] pitch;
		logic signed [9:0] yaw;
	} rc_cmd_t;

endpackage

// File: pwm_reader/pwm_reader.sv
//======================================================================
// Single-channel PWM reader: pin synchronizer, glitch-tolerant FSM
// and a clamped pulse-length output with a one-cycle done strobe
//======================================================================

`timescale 1ns/1ps

`include "rc_params.svh"

module pwm_reader #(
	parameter logic [15:0] default_us = `RC_CENTER_US
) (
	input  logic        us_clk,
	input  logic        resetn,
	input  logic        pwm,
	output logic [15:0] pulse_length_us,
	output logic        pulse_done
);

	import rc_pkg::*;

	// Two-flop synchronizer for the asynchronous receiver pin
	logic pwm_meta;
	logic pwm_sync;

	// Reader FSM and the running high-time count
	pwm_state_e  state;
	logic [15:0] high_count;

	// Set for one cycle after a falling edge has been confirmed
	logic fall_seen;

	// Count limited to the legal window
	logic [15:0] clamped;

	// Adds a small step to the count and sticks at all ones
	// A stuck-high pin therefore cannot wrap into a legal value
	function automatic logic [15:0] sat_add(input logic [15:0] value,
	                                        input logic [1:0]  step);
		logic [16:0] sum;
		sum = {1'b0, value} + {15'd0, step};
		if (sum[16])
			return 16'hffff;
		return sum[15:0];
	endfunction

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			pwm_meta <= 1'b0;
			pwm_sync <= 1'b0;
		end else begin
			pwm_meta <= pwm;
			pwm_sync <= pwm_meta;
		end
	end

	// Every synchronized high sample is counted, including the first one
	// that only opened the confirm window
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			state      <= INIT;
			high_count <= '0;
			fall_seen  <= 1'b0;
		end else begin
			fall_seen <= 1'b0;
			case (state)
				INIT: begin
					state      <= LOW;
					high_count <= '0;
				end
				LOW: begin
					// First high sample, count it and wait for a second one
					if (pwm_sync) begin
						state      <= CONFIRM_HIGH;
						high_count <= 16'd1;
					end else begin
						high_count <= '0;
					end
				end
				CONFIRM_HIGH: begin
					if (pwm_sync) begin
						state      <= HIGH;
						high_count <= sat_add(high_count, 2'd1);
					end else begin
						// Lone high sample in the gap, drop it
						state      <= LOW;
						high_count <= '0;
					end
				end
				HIGH: begin
					if (pwm_sync)
						high_count <= sat_add(high_count, 2'd1);
					else
						state <= CONFIRM_LOW;
				end
				CONFIRM_LOW: begin
					if (pwm_sync) begin
						// The low sample was a glitch, so it counts as high
						// together with the sample that follows it
						state      <= HIGH;
						high_count <= sat_add(high_count, 2'd2);
					end else begin
						// Second low sample, the pulse has really ended
						// The count is kept one more cycle for the publish stage
						state     <= LOW;
						fall_seen <= 1'b1;
					end
				end
				default: begin
					state      <= INIT;
					high_count <= '0;
				end
			endcase
		end
	end

	always_comb begin
		if (high_count < `RC_MIN_PULSE_US)
			clamped = `RC_MIN_PULSE_US;
		else if (high_count > `RC_MAX_PULSE_US)
			clamped = `RC_MAX_PULSE_US;
		else
			clamped = high_count;
	end

	// Publish stage, the length and its strobe change in the same cycle
	// which is four cycles after the first low sample at the pin
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			pulse_length_us <= default_us;
			pulse_done      <= 1'b0;
		end else begin
			pulse_done <= fall_seen;
			if (fall_seen)
				pulse_length_us <= clamped;
		end
	end

endmodule

// File: rtl/rc_link_monitor.sv
//======================================================================
// Link monitor: per-channel stale counters, link-lost flag and
// failsafe substitution on the pulse bundle
//======================================================================

`timescale 1ns/1ps

`include "rc_params.svh"

module rc_link_monitor (
	input  logic              us_clk,
	input  logic              resetn,
	input  rc_pkg::rc_pulses_t pulses_in,
	input  logic [3:0]        pulse_done,
	output rc_pkg::rc_pulses_t pulses_out,
	output logic              link_lost
);

	import rc_pkg::*;

	// Cycles since the last measured pulse, saturating at the timeout
	logic [`RC_LINK_CNT_W-1:0] stale_cnt [4];
	logic [`RC_LINK_CNT_W-1:0] cnt_next [4];

	// Channel will be at the timeout after this cycle
	logic [3:0] expired;

	// Channels that delivered a pulse since the link was lost
	logic [3:0] seen;
	logic [3:0] seen_next;

	logic       lost_next;
	rc_pulses_t failsafe;

	// Throttle falls back to idle, the axes to the centre
	function automatic logic [15:0] chan_failsafe(input rc_chan_e ch);
		return (ch == THROTTLE) ? `RC_MIN_PULSE_US : `RC_CENTER_US;
	endfunction

	assign failsafe = '{
		throttle: chan_failsafe(THROTTLE),
		roll:     chan_failsafe(ROLL),
		pitch:    chan_failsafe(PITCH),
		yaw:      chan_failsafe(YAW)
	};

	always_comb begin
		for (int i = 0; i < 4; i++) begin
			if (pulse_done[i])
				cnt_next[i] = '0;
			else if (stale_cnt[i] == `RC_LINK_TIMEOUT_US)
				cnt_next[i] = stale_cnt[i];
			else
				cnt_next[i] = stale_cnt[i] + 1'b1;
			expired[i] = (cnt_next[i] == `RC_LINK_TIMEOUT_US);
		end

		// Strobes in the cycle the link drops already count toward recovery
		// A channel that goes stale again during the loss must deliver anew
		if (link_lost)
			seen_next = pulse_done | (seen & ~expired);
		else
			seen_next = pulse_done;

		// Recovery needs one fresh pulse on every channel
		if (link_lost)
			lost_next = ~&seen_next;
		else
			lost_next = |expired;
	end

	// Reset starts in the lost state with every counter already expired
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			stale_cnt  <= '{default: `RC_LINK_TIMEOUT_US};
			seen       <= '0;
			link_lost  <= 1'b1;
			pulses_out <= failsafe;
		end else begin
			stale_cnt <= cnt_next;
			seen      <= seen_next;
			link_lost <= lost_next;
			// The failsafe set is held one cycle past recovery as well
			// so the command stays safe two cycles after any lost cycle
			if (lost_next || link_lost)
				pulses_out <= failsafe;
			else
				pulses_out <= pulses_in;
		end
	end

endmodule

// File: rtl/rc_cmd_mapper.sv
//======================================================================
// Command mapper: pulse lengths to throttle and deadbanded axis values
//======================================================================

`timescale 1ns/1ps

`include "rc_params.svh"

module rc_cmd_mapper (
	input  logic               us_clk,
	input  logic               resetn,
	input  rc_pkg::rc_pulses_t pulses,
	output rc_pkg::rc_cmd_t    cmd
);

	import rc_pkg::*;

	// Channel lengths by index, taken apart from the bundle
	logic [15:0] len [4];

	// Throttle above the bottom of the window
	logic [15:0] thr_off;

	rc_cmd_t cmd_next;

	// Signed offset from centre, zero inside the deadband
	// The input is already clamped so the result fits -500..500
	function automatic logic signed [9:0] map_axis(input logic [15:0] width);
		logic signed [16:0] offset;
		logic        [16:0] magnitude;
		offset    = $signed({1'b0, width}) - $signed({1'b0, `RC_CENTER_US});
		magnitude = offset[16] ? -offset : offset;
		if (magnitude <= {1'b0, `RC_DEADBAND_US})
			return '0;
		return $signed(offset[9:0]);
	endfunction

	assign len[THROTTLE] = pulses.throttle;
	assign len[ROLL]     = pulses.roll;
	assign len[PITCH]    = pulses.pitch;
	assign len[YAW]      = pulses.yaw;

	assign thr_off = len[THROTTLE] - `RC_MIN_PULSE_US;

	always_comb begin
		cmd_next.throttle = thr_off[9:0];
		cmd_next.roll     = map_axis(len[ROLL]);
		cmd_next.pitch    = map_axis(len[PITCH]);
		cmd_next.yaw      = map_axis(len[YAW]);
	end

	// Zero throttle and centred axes out of reset
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn)
			cmd <= '0;
		else
			cmd <= cmd_next;
	end

endmodule

// File: rtl/rc_input_top.sv
//======================================================================
// RC input subsystem top: four PWM readers, link monitor, mapper
//======================================================================

`timescale 1ns/1ps

`include "rc_params.svh"

module rc_input_top (
	input  logic            us_clk,
	input  logic            resetn,
	input  logic [3:0]      pwm,
	output rc_pkg::rc_cmd_t cmd,
	output logic            link_lost
);

	import rc_pkg::*;

	// Reader outputs, indexed by channel
	logic [15:0] len [4];
	logic [3:0]  done;

	// Live lengths and the lengths after failsafe substitution
	rc_pulses_t pulses_raw;
	rc_pulses_t pulses_safe;

	// Throttle idles at the bottom of the window, the axes at centre
	pwm_reader #(.default_us(`RC_MIN_PULSE_US)) u_reader_throttle (
		.us_clk, .resetn, .pwm(pwm[THROTTLE]),
		.pulse_length_us(len[THROTTLE]), .pulse_done(done[THROTTLE])
	);
	pwm_reader #(.default_us(`RC_CENTER_US)) u_reader_roll (
		.us_clk, .resetn, .pwm(pwm[ROLL]),
		.pulse_length_us(len[ROLL]), .pulse_done(done[ROLL])
	);
	pwm_reader #(.default_us(`RC_CENTER_US)) u_reader_pitch (
		.us_clk, .resetn, .pwm(pwm[PITCH]),
		.pulse_length_us(len[PITCH]), .pulse_done(done[PITCH])
	);
	pwm_reader #(.default_us(`RC_CENTER_US)) u_reader_yaw (
		.us_clk, .resetn, .pwm(pwm[YAW]),
		.pulse_length_us(len[YAW]), .pulse_done(done[YAW])
	);

	assign pulses_raw = '{
		throttle: len[THROTTLE],
		roll:     len[ROLL],
		pitch:    len[PITCH],
		yaw:      len[YAW]
	};

	rc_link_monitor u_monitor (
		.us_clk, .resetn, .pulses_in(pulses_raw), .pulse_done(done),
		.pulses_out(pulses_safe), .link_lost
	);

	rc_cmd_mapper u_mapper (
		.us_clk, .resetn, .pulses(pulses_safe), .cmd
	);

endmodule

// File: verif/rc_input_chk.sv
//======================================================================
// Concurrent checks on the reader strobes, command range and failsafe
//======================================================================

`timescale 1ns/1ps

module rc_input_chk (
	input logic            us_clk,
	input logic            resetn,
	input logic [3:0]      done,
	input rc_pkg::rc_cmd_t cmd,
	input logic            link_lost
);

	// Each reader strobe lasts exactly one cycle
	done_single: assert property (@(posedge us_clk) disable iff (!resetn)
		(done & $past(done)) == 4'b0)
		else $error("pulse_done high for two cycles, strobes 0x%h", done);

	throttle_range: assert property (@(posedge us_clk) disable iff (!resetn)
		cmd.throttle <= 10'd1000)
		else $error("throttle command 0x%h above full scale", cmd.throttle);

	// Axis commands stay within half the pulse window around centre
	axis_range: assert property (@(posedge us_clk) disable iff (!resetn)
		cmd.roll >= -10'sd500 && cmd.roll <= 10'sd500 &&
		cmd.pitch >= -10'sd500 && cmd.pitch <= 10'sd500 &&
		cmd.yaw >= -10'sd500 && cmd.yaw <= 10'sd500)
		else $error("axis command out of range, cmd 0x%h", cmd);

	// A lost link reaches the command two cycles later as idle throttle, centred sticks
	failsafe_cmd: assert property (@(posedge us_clk) disable iff (!resetn)
		$past(link_lost, 2) |-> cmd == '0)
		else $error("command 0x%h not at failsafe after link loss", cmd);

endmodule

bind rc_input_top rc_input_chk u_chk (
	.us_clk(us_clk),
	.resetn(resetn),
	.done(done),
	.cmd(cmd),
	.link_lost(link_lost)
);

// File: verif/rc_input_tb.sv
//======================================================================
// Directed testbench of the RC input subsystem: pulse driver, expected
// command model, link-loss sequence, watchdog and verdict
//======================================================================

`timescale 1ns/1ps

`include "rc_params.svh"

module rc_input_tb;

	import rc_pkg::*;

	localparam int MIN_US      = int'(`RC_MIN_PULSE_US);
	localparam int MAX_US      = int'(`RC_MAX_PULSE_US);
	localparam int CENTER_US   = int'(`RC_CENTER_US);
	localparam int DEADBAND_US = int'(`RC_DEADBAND_US);
	localparam int TIMEOUT_US  = int'(`RC_LINK_TIMEOUT_US);
	localparam int GAP_CYCLES  = 200;

	// About 40 frames of 2400 cycles and 3 link timeouts plus half of that again
	localparam int WATCHDOG_CYCLES = (40 * 2400 + 3 * TIMEOUT_US) * 3 / 2;

	logic       us_clk;
	logic       resetn;
	logic [3:0] pwm;
	rc_cmd_t    cmd;
	logic       link_lost;

	// DUT outputs sampled ten cycles after the last falling edge of a frame
	rc_cmd_t cmd_mid;
	logic    lost_mid;

	logic [31:0] rng_state;
	int          checks_run;
	int          checks_failed;
	int          test_failed;

	rc_input_top UUT (.us_clk, .resetn, .pwm, .cmd, .link_lost);

	initial begin
		us_clk = 1'b0;
		forever #50 us_clk = ~us_clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	// Any measured length ends up inside the legal window
	function automatic int clamp_width(input int w);
		if (w < MIN_US)
			return MIN_US;
		if (w > MAX_US)
			return MAX_US;
		return w;
	endfunction

	// The offset from centre is zero while the stick sits in the deadband
	function automatic int axis_value(input int w);
		int offset;
		offset = clamp_width(w) - CENTER_US;
		if (offset <= DEADBAND_US && offset >= -DEADBAND_US)
			return 0;
		return offset;
	endfunction

	// Pin level in cycle c of a pulse w long, with an optional low sample halfway
	function automatic logic pin_level(input int c, input int w, input logic glitch);
		return (c < w) && !(glitch && c == w / 2);
	endfunction

	task automatic step();
		@(posedge us_clk);
		#10;
	endtask

	task automatic check_value(input string name, input logic [15:0] got,
	                           input logic [15:0] want);
		checks_run++;
		assert (got === want) else begin
			$display("[FAIL] %s got 0x%04h expected 0x%04h", name, got, want);
			checks_failed++;
			test_failed++;
		end
	endtask

	task automatic expect_true(input logic cond, input string text);
		checks_run++;
		assert (cond === 1'b1) else begin
			$display("%s", text);
			checks_failed++;
			test_failed++;
		end
	endtask

	// Throttle counts up from the bottom of the window and the axes follow the deadband rule
	task automatic check_cmd(input rc_cmd_t got, input int w_thr, input int w_roll,
	                         input int w_pitch, input int w_yaw);
		check_value("cmd.throttle", 16'(got.throttle), 16'(clamp_width(w_thr) - MIN_US));
		check_value("cmd.roll", 16'(got.roll), 16'(axis_value(w_roll)));
		check_value("cmd.pitch", 16'(got.pitch), 16'(axis_value(w_pitch)));
		check_value("cmd.yaw", 16'(got.yaw), 16'(axis_value(w_yaw)));
	endtask

	// All four pulses rise together and each falls after its own width
	// A width of zero leaves that channel silent for the frame
	task automatic drive_pulses(input int w_thr, input int w_roll, input int w_pitch,
	                            input int w_yaw, input logic [3:0] mid_glitch,
	                            input logic [3:0] gap_spike);
		int longest;
		longest = w_thr;
		if (w_roll > longest)
			longest = w_roll;
		if (w_pitch > longest)
			longest = w_pitch;
		if (w_yaw > longest)
			longest = w_yaw;
		for (int c = 0; c < longest; c++) begin
			pwm = {pin_level(c, w_yaw, mid_glitch[YAW]),
			       pin_level(c, w_pitch, mid_glitch[PITCH]),
			       pin_level(c, w_roll, mid_glitch[ROLL]),
			       pin_level(c, w_thr, mid_glitch[THROTTLE])};
			step();
		end
		pwm = '0;
		for (int g = 0; g < GAP_CYCLES; g++) begin
			step();
			if (g == 9) begin
				cmd_mid  = cmd;
				lost_mid = link_lost;
			end
			// One lone high sample well inside the gap
			pwm = (g == 49) ? gap_spike : 4'b0;
		end
	endtask

	task automatic next_width(output int w);
		rng_state = xorshift32(rng_state);
		w = MIN_US + int'(rng_state % 32'd1001);
	endtask

	task automatic end_test(input string name);
		if (test_failed == 0)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d checks failed", name, test_failed);
		test_failed = 0;
	endtask

	task automatic reset_values();
		repeat (3) step();
		check_value("link_lost", 16'(link_lost), 16'd1);
		check_cmd(cmd, MIN_US, CENTER_US, CENTER_US, CENTER_US);
		end_test("reset");
	endtask

	task automatic random_widths();
		int w [4];
		for (int n = 0; n < 12; n++) begin
			next_width(w[THROTTLE]);
			next_width(w[ROLL]);
			next_width(w[PITCH]);
			next_width(w[YAW]);
			drive_pulses(w[THROTTLE], w[ROLL], w[PITCH], w[YAW], 4'b0, 4'b0);
			// The first complete set already clears the power-up loss
			check_value("link_lost", 16'(lost_mid), 16'd0);
			check_cmd(cmd_mid, w[THROTTLE], w[ROLL], w[PITCH], w[YAW]);
		end
		end_test("random widths");
	endtask

	task automatic width_clamping();
		drive_pulses(600, 600, 600, 600, 4'b0, 4'b0);
		check_cmd(cmd_mid, 600, 600, 600, 600);
		drive_pulses(2600, 2600, 2600, 2600, 4'b0, 4'b0);
		check_cmd(cmd_mid, 2600, 2600, 2600, 2600);
		end_test("clamping");
	endtask

	task automatic deadband_edges();
		drive_pulses(1500, 1480, 1520, 1521, 4'b0, 4'b0);
		check_cmd(cmd_mid, 1500, 1480, 1520, 1521);
		drive_pulses(1500, 1479, 1521, 1520, 4'b0, 4'b0);
		check_cmd(cmd_mid, 1500, 1479, 1521, 1520);
		end_test("deadband");
	endtask

	task automatic glitch_rejection();
		drive_pulses(1700, 1300, 1600, 1400, 4'hf, 4'hf);
		check_cmd(cmd_mid, 1700, 1300, 1600, 1400);
		// The spike in the gap must not have produced a new measurement
		check_cmd(cmd, 1700, 1300, 1600, 1400);
		end_test("glitch rejection");
	endtask

	task automatic link_loss_recovery();
		int waited;
		drive_pulses(1700, 1600, 1400, 1500, 4'b0, 4'b0);
		check_value("link_lost", 16'(lost_mid), 16'd0);
		// Yaw goes quiet while the other sticks keep moving
		drive_pulses(1700, 1600, 1400, 0, 4'b0, 4'b0);
		check_cmd(cmd_mid, 1700, 1600, 1400, 1500);
		waited = 0;
		while (!link_lost && waited < 2 * TIMEOUT_US) begin
			step();
			waited++;
		end
		expect_true(link_lost, "link_lost did not rise after the yaw pulses stopped");
		repeat (10) step();
		check_cmd(cmd, MIN_US, CENTER_US, CENTER_US, CENTER_US);
		// Yaw returns alone while the other channels have sent nothing since the loss
		drive_pulses(0, 0, 0, 1500, 4'b0, 4'b0);
		check_value("link_lost", 16'(link_lost), 16'd1);
		check_cmd(cmd, MIN_US, CENTER_US, CENTER_US, CENTER_US);
		drive_pulses(1600, 1550, 1450, 1700, 4'b0, 4'b0);
		check_value("link_lost", 16'(lost_mid), 16'd0);
		check_cmd(cmd_mid, 1600, 1550, 1450, 1700);
		end_test("link loss and recovery");
	endtask

	initial begin
		resetn        = 1'b0;
		pwm           = 4'b0;
		rng_state     = 32'd50543;
		checks_run    = 0;
		checks_failed = 0;
		test_failed   = 0;
		repeat (4) @(posedge us_clk);
		#10;
		resetn = 1'b1;
		reset_values();
		random_widths();
		width_clamping();
		deadband_edges();
		glitch_rejection();
		link_loss_recovery();
		$display("%0d checks run, %0d failed", checks_run, checks_failed);
		if (checks_failed == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

	// Ends a run that hangs somewhere in the tests
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge us_clk);
		$display("watchdog expired before the tests finished");
		$display(">>> FAIL");
		$finish;
	end

endmodule

// File: list.f
+incdir+common
common/rc_pkg.sv
pwm_reader/pwm_reader.sv
rtl/rc_link_monitor.sv
rtl/rc_cmd_mapper.sv
rtl/rc_input_top.sv
verif/rc_input_chk.sv
verif/rc_input_tb.sv

// File: run.sh
#!/bin/sh
# Builds the RC input testbench with Verilator and runs it.
# The run passes only when the pass line appears in the simulation output.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module rc_input_tb -o rc_input_sim \
	&& ./obj_dir/rc_input_sim | tee /dev/stderr | grep -x '>>> PASS' > /dev/null \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
